// File: all.f
hdl/mem_ctrl_pkg.sv
hdl/refill_fsm.sv
hdl/victim_select.sv
hdl/fill_router.sv
hdl/mem_ctrl_top.sv
bench/tb_mem_ctrl.sv

// File: bench/tb_mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_ctrl import mem_ctrl_pkg::*; ();

    localparam int L2_WAYS = 4;
    localparam int TIMEOUT = 100;  // cycles per wait

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        access_clean;
    logic                        access_dirty;
    l2_req_t                     req;
    l2_tag_entry_t [L2_WAYS-1:0] way_tags;
    line_t [L2_WAYS-1:0]         way_lines;
    logic                        mem_complete_r = 1'b0;
    logic                        mem_complete_w = 1'b0;
    line_t                       mem_rd = '0;
    logic                        busy;
    logic                        mem_re;
    logic                        mem_we;
    logic [MEM_ADDR_W-1:0]       mem_addr;
    line_t                       mem_wd;
    l2_fill_t                    l2_fill;
    l1_fill_t                    l1_fill;
    logic                        replay;

    int   seed        = 82016;
    int   mem_wait    = 0;
    logic mem_active  = 1'b0;
    int   writes_done = 0;

    always #5 clk = ~clk;

    mem_ctrl_top #(
        .L2_WAYS (L2_WAYS)
    ) u_mem_ctrl_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .access_clean   (access_clean),
        .access_dirty   (access_dirty),
        .req            (req),
        .way_tags       (way_tags),
        .way_lines      (way_lines),
        .busy           (busy),
        .l2_fill        (l2_fill),
        .l1_fill        (l1_fill),
        .replay         (replay),
        .mem_complete_r (mem_complete_r),
        .mem_complete_w (mem_complete_w),
        .mem_rd         (mem_rd),
        .mem_re         (mem_re),
        .mem_we         (mem_we),
        .mem_addr       (mem_addr),
        .mem_wd         (mem_wd)
    );

    ////////////////////
    // reference model
    ////////////////////
    // every 32-bit chunk carries its index and the full line address
    function automatic line_t line_pattern(input logic [MEM_ADDR_W-1:0] a);
        line_t l;
        for (int i = 0; i < 16; i++) begin
            l[i*32 +: 32] = {4'(i), a, 2'b01};
        end
        return l;
    endfunction

    function automatic logic [MEM_ADDR_W-1:0] refill_addr(input l2_req_t r);
        return r.addr[27:2];
    endfunction

    function automatic logic [MEM_ADDR_W-1:0] victim_mem_addr(input l2_tag_entry_t t,
                                                              input l2_req_t r);
        return {t.tag, r.addr[10:2]};  // old tag, request set
    endfunction

    function automatic l2_fill_t expect_l2_fill(input l2_req_t r, input line_t l);
        l2_fill_t f;
        f.way_we    = 4'b0001 << r.l2_way;
        f.set       = r.addr[10:2];
        f.tag.valid = 1'b1;
        f.tag.tag   = r.addr[27:11];
        f.line      = l;
        return f;
    endfunction

    function automatic l1_fill_t expect_l1_fill(input l2_req_t r, input line_t l);
        l1_fill_t   f;
        logic [1:0] way_oh;
        way_oh  = r.l1_way ? 2'b10 : 2'b01;
        f.ic_we = r.to_ic ? way_oh : 2'b00;
        f.dc_we = r.to_dc ? way_oh : 2'b00;
        f.index = r.addr[7:0];
        f.tag   = {1'b1, r.addr[27:8]};
        f.word  = l[int'(r.addr[1:0]) * 128 +: 128];
        return f;
    endfunction

    ////////////////////
    // compare tasks
    ////////////////////
    task automatic stop_run(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL %s got 0x%h exp 0x%h", name, got, exp));
        end
    endtask

    task automatic check_mem_access(input logic [MEM_ADDR_W-1:0] exp_addr,
                                    input line_t exp_data, input logic with_data);
        if (mem_addr !== exp_addr) begin
            stop_run($sformatf("FAIL mem_addr got 0x%h exp 0x%h", mem_addr, exp_addr));
        end
        if (with_data && mem_wd !== exp_data) begin
            stop_run($sformatf("FAIL mem_wd got 0x%h exp 0x%h", mem_wd, exp_data));
        end
    endtask

    task automatic check_l2_fill(input l2_fill_t exp);
        if (l2_fill !== exp) begin
            stop_run($sformatf("FAIL l2_fill got 0x%h exp 0x%h", l2_fill, exp));
        end
    endtask

    task automatic check_l1_fill(input l1_fill_t exp);
        if (l1_fill !== exp) begin
            stop_run($sformatf("FAIL l1_fill got 0x%h exp 0x%h", l1_fill, exp));
        end
    endtask

    ////////////////////
    // memory model
    ////////////////////
    always @(negedge clk) begin
        mem_complete_r = 1'b0;
        mem_complete_w = 1'b0;
        if (!rst_n) begin
            mem_active = 1'b0;
        end else if (!mem_active && (mem_re || mem_we)) begin
            mem_active = 1'b1;
            mem_wait   = 1 + ($unsigned($random(seed)) % 8);  // 1 to 8 cycles
        end else if (mem_active) begin
            mem_wait = mem_wait - 1;
            if (mem_wait == 0) begin
                mem_active = 1'b0;
                if (mem_we) begin
                    mem_complete_w = 1'b1;
                    writes_done++;
                end else begin
                    mem_rd         = line_pattern(mem_addr);
                    mem_complete_r = 1'b1;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && mem_re && mem_we) begin
            stop_run("mem_re and mem_we were high in the same cycle");
        end
    end

    ////////////////////
    // stimulus
    ////////////////////
    task automatic randomize_set();
        for (int w = 0; w < L2_WAYS; w++) begin
            way_tags[w] = 18'($random(seed));
            for (int c = 0; c < 16; c++) begin
                way_lines[w][c*32 +: 32] = $random(seed);
            end
        end
    endtask

    // one miss from request to fill; poke holds a second request while busy
    task automatic run_miss(input l2_req_t r, input logic dirty, input logic poke);
        l2_tag_entry_t vtag;
        line_t         vline;
        line_t         rline;
        int            n;
        int            wb_before;
        randomize_set();
        vtag         = way_tags[r.l2_way];
        vline        = way_lines[r.l2_way];
        rline        = line_pattern(refill_addr(r));
        req          = r;
        access_clean = !dirty;
        access_dirty = dirty;
        wb_before    = writes_done;
        @(negedge clk);
        access_clean = 1'b0;
        access_dirty = 1'b0;
        randomize_set();  // captured victim must not follow the L2 side
        check_bit("busy", busy, 1'b1);
        if (dirty) begin
            n = 0;
            while (!mem_re) begin
                check_bit("mem_we", mem_we, 1'b1);
                check_mem_access(victim_mem_addr(vtag, r), vline, 1'b1);
                @(negedge clk);
                n++;
                if (n > TIMEOUT) stop_run("timeout waiting for mem_re after the write-back");
            end
            check_bit("mem_complete_w seen", writes_done == wb_before + 1, 1'b1);
        end
        n = 0;
        while (l2_fill.way_we == '0) begin
            check_bit("mem_re", mem_re, 1'b1);
            check_bit("mem_we", mem_we, 1'b0);
            check_bit("busy", busy, 1'b1);
            check_bit("replay", replay, 1'b0);
            check_mem_access(refill_addr(r), '0, 1'b0);
            if (poke) begin
                req.addr     = ~r.addr;
                req.l2_way   = r.l2_way + 2'd1;
                access_dirty = 1'b1;  // ignored while busy
            end
            @(negedge clk);
            n++;
            if (n > TIMEOUT) stop_run("timeout waiting for the L2 fill");
        end
        access_dirty = 1'b0;
        check_bit("busy", busy, 1'b0);
        check_bit("mem_re", mem_re, 1'b0);
        check_l2_fill(expect_l2_fill(r, rline));
        if (r.is_write) begin
            check_bit("replay", replay, 1'b1);
            check_bit("l1_fill.ic_we", |l1_fill.ic_we, 1'b0);
            check_bit("l1_fill.dc_we", |l1_fill.dc_we, 1'b0);
        end else begin
            check_bit("replay", replay, 1'b0);
            check_l1_fill(expect_l1_fill(r, rline));
        end
        @(negedge clk);
        check_bit("l2_fill.way_we", |l2_fill.way_we, 1'b0);
        check_bit("l1_fill.ic_we", |l1_fill.ic_we, 1'b0);
        check_bit("l1_fill.dc_we", |l1_fill.dc_we, 1'b0);
        check_bit("replay", replay, 1'b0);
        check_bit("mem_re", mem_re, 1'b0);  // no access left from the poke
        check_bit("mem_we", mem_we, 1'b0);
    endtask

    task automatic check_idle();
        check_bit("busy", busy, 1'b0);
        check_bit("mem_re", mem_re, 1'b0);
        check_bit("mem_we", mem_we, 1'b0);
        check_bit("l2_fill.way_we", |l2_fill.way_we, 1'b0);
        check_bit("l1_fill.ic_we", |l1_fill.ic_we, 1'b0);
        check_bit("l1_fill.dc_we", |l1_fill.dc_we, 1'b0);
        check_bit("replay", replay, 1'b0);
    endtask

    initial begin
        l2_req_t r;
        rst_n        = 1'b0;
        access_clean = 1'b0;
        access_dirty = 1'b0;
        req          = '0;
        way_tags     = '0;
        way_lines    = '0;
        repeat (4) @(negedge clk);
        check_idle();
        rst_n = 1'b1;
        @(negedge clk);
        check_idle();

        // clean read miss for the instruction cache
        r = '{addr: 28'($random(seed)), l2_way: 2'd1, l1_way: 1'b1,
              is_write: 1'b0, to_ic: 1'b1, to_dc: 1'b0};
        run_miss(r, 1'b0, 1'b0);

        // dirty misses, with a request held high during the refill
        r = '{addr: 28'($random(seed)), l2_way: 2'd2, l1_way: 1'b0,
              is_write: 1'b0, to_ic: 1'b1, to_dc: 1'b0};
        run_miss(r, 1'b1, 1'b1);
        r = '{addr: 28'($random(seed)), l2_way: 2'd3, l1_way: 1'b1,
              is_write: 1'b0, to_ic: 1'b0, to_dc: 1'b1};
        run_miss(r, 1'b1, 1'b0);

        // data cache, every offset and both L1 ways
        for (int off = 0; off < WORDS_PER_LINE; off++) begin
            for (int w = 0; w < 2; w++) begin
                r = '{addr: {26'($random(seed)), 2'(off)}, l2_way: 2'(off), l1_way: 1'(w),
                      is_write: 1'b0, to_ic: 1'b0, to_dc: 1'b1};
                run_miss(r, 1'b0, w == 1);
            end
        end

        // write misses end in a replay
        r = '{addr: 28'($random(seed)), l2_way: 2'd0, l1_way: 1'b1,
              is_write: 1'b1, to_ic: 1'b0, to_dc: 1'b1};
        run_miss(r, 1'b0, 1'b0);
        r = '{addr: 28'($random(seed)), l2_way: 2'd1, l1_way: 1'b0,
              is_write: 1'b1, to_ic: 1'b0, to_dc: 1'b1};
        run_miss(r, 1'b1, 1'b1);

        check_idle();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/fill_router.sv
`timescale 1ns/1ps
`default_nettype none

module fill_router import mem_ctrl_pkg::*; #(
    parameter int L2_WAYS = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     fill_go,
    input  l2_req_t  active_req,
    input  line_t    mem_rd,
    output l2_fill_t l2_fill,
    output l1_fill_t l1_fill,
    output logic     replay
);

    localparam int SEL_W = (L2_WAYS > 1) ? $clog2(L2_WAYS) : 1;
    localparam int OFF_W = $clog2(WORDS_PER_LINE);

    logic [SEL_W-1:0] way_sel;
    logic [3:0]       way_dec;
    logic [OFF_W-1:0] off;
    word_t            fill_word;
    logic [1:0]       l1_oh;
    logic             rd_fill;

    // strobes
    logic [3:0] way_we_q;
    logic [1:0] ic_we_q;
    logic [1:0] dc_we_q;
    logic       replay_q;

    // payload
    logic [L2_SET_W-1:0] set_q;
    l2_tag_entry_t       tag_q;
    line_t               line_q;
    logic [L1_IDX_W-1:0] idx_q;
    logic [L1_TAG_W:0]   l1_tag_q;
    word_t               word_q;

    assign way_sel = SEL_W'(active_req.l2_way);
    assign off     = addr_offset(active_req.addr);
    assign l1_oh   = active_req.l1_way ? 2'b10 : 2'b01;
    assign rd_fill = fill_go && !active_req.is_write;

    always_comb begin
        way_dec          = '0;
        way_dec[way_sel] = 1'b1;
    end

    // addressed word out of the returned line
    always_comb begin
        fill_word = '0;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            if (off == w) begin
                fill_word = mem_rd[w*WORD_W +: WORD_W];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            way_we_q <= '0;
            ic_we_q  <= '0;
            dc_we_q  <= '0;
            replay_q <= 1'b0;
        end else begin
            way_we_q <= fill_go ? way_dec : '0;  // single-cycle strobes
            ic_we_q  <= (rd_fill && active_req.to_ic) ? l1_oh : 2'b00;
            dc_we_q  <= (rd_fill && active_req.to_dc) ? l1_oh : 2'b00;
            replay_q <= fill_go && active_req.is_write;  // store retries in L2
        end
    end

    always_ff @(posedge clk) begin
        if (fill_go) begin
            set_q    <= addr_l2_set(active_req.addr);
            tag_q    <= '{valid: 1'b1, tag: addr_l2_tag(active_req.addr)};
            line_q   <= mem_rd;
            idx_q    <= addr_l1_index(active_req.addr);
            l1_tag_q <= {1'b1, addr_l1_tag(active_req.addr)};
            word_q   <= fill_word;
        end
    end

    assign l2_fill = '{way_we: way_we_q, set: set_q, tag: tag_q, line: line_q};
    assign l1_fill = '{ic_we: ic_we_q, dc_we: dc_we_q, index: idx_q,
                       tag: l1_tag_q, word: word_q};
    assign replay  = replay_q;

    ////////////////////
    // checks
    ////////////////////
    a_way_we_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(l2_fill.way_we)
    ) else $error("L2 way_we not one-hot");

    a_way_we_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        (l2_fill.way_we != '0) |=> (l2_fill.way_we == '0)
    ) else $error("L2 way_we longer than one cycle");

endmodule

`default_nettype wire

// File: hdl/mem_ctrl_pkg.sv
`default_nettype none

package mem_ctrl_pkg;

    ////////////////////
    // widths
    ////////////////////
    localparam int ADDR_W         = 28;  // request address, 128-bit words
    localparam int WORD_W         = 128;
    localparam int LINE_W         = 512;
    localparam int MEM_ADDR_W     = 26;  // memory line address
    localparam int L2_TAG_W       = 17;
    localparam int L2_SET_W       = 9;
    localparam int L1_TAG_W       = 20;
    localparam int L1_IDX_W       = 8;
    localparam int WORDS_PER_LINE = 4;

    typedef logic [LINE_W-1:0] line_t;
    typedef logic [WORD_W-1:0] word_t;

    typedef struct packed {
        logic                valid;
        logic [L2_TAG_W-1:0] tag;
    } l2_tag_entry_t;

    // one miss from the L2 side
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [1:0]        l2_way;
        logic              l1_way;    // way 0 or 1 of the L1
        logic              is_write;  // miss came from a store
        logic              to_ic;
        logic              to_dc;
    } l2_req_t;

    typedef struct packed {
        logic [3:0]          way_we;  // one-hot
        logic [L2_SET_W-1:0] set;
        l2_tag_entry_t       tag;
        line_t               line;
    } l2_fill_t;

    typedef struct packed {
        logic [1:0]          ic_we;   // one-hot per L1 way
        logic [1:0]          dc_we;
        logic [L1_IDX_W-1:0] index;
        logic [L1_TAG_W:0]   tag;     // valid bit on top
        word_t               word;
    } l1_fill_t;

    ////////////////////
    // address fields
    ////////////////////
    function automatic logic [1:0] addr_offset(input logic [ADDR_W-1:0] a);
        return a[1:0];
    endfunction

    function automatic logic [L2_SET_W-1:0] addr_l2_set(input logic [ADDR_W-1:0] a);
        return a[L2_SET_W+1:2];
    endfunction

    function automatic logic [L2_TAG_W-1:0] addr_l2_tag(input logic [ADDR_W-1:0] a);
        return a[ADDR_W-1:ADDR_W-L2_TAG_W];
    endfunction

    function automatic logic [L1_IDX_W-1:0] addr_l1_index(input logic [ADDR_W-1:0] a);
        return a[L1_IDX_W-1:0];
    endfunction

    function automatic logic [L1_TAG_W-1:0] addr_l1_tag(input logic [ADDR_W-1:0] a);
        return a[ADDR_W-1:L1_IDX_W];
    endfunction

    function automatic logic [MEM_ADDR_W-1:0] addr_line(input logic [ADDR_W-1:0] a);
        return a[ADDR_W-1:2];  // drop word offset
    endfunction

endpackage

`default_nettype wire

// File: hdl/mem_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_top import mem_ctrl_pkg::*; #(
    parameter int L2_WAYS = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    // L2 side
    input  logic                        access_clean,
    input  logic                        access_dirty,
    input  l2_req_t                     req,
    input  l2_tag_entry_t [L2_WAYS-1:0] way_tags,   // chosen set
    input  line_t [L2_WAYS-1:0]         way_lines,
    output logic                        busy,
    output l2_fill_t                    l2_fill,
    output l1_fill_t                    l1_fill,
    output logic                        replay,
    // memory side
    input  logic                        mem_complete_r,
    input  logic                        mem_complete_w,
    input  line_t                       mem_rd,
    output logic                        mem_re,
    output logic                        mem_we,
    output logic [MEM_ADDR_W-1:0]       mem_addr,
    output line_t                       mem_wd
);

    logic                  capture;
    logic [1:0]            victim_way;
    logic                  fill_go;
    l2_req_t               active_req;
    logic [MEM_ADDR_W-1:0] victim_addr;

    refill_fsm u_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .access_clean   (access_clean),
        .access_dirty   (access_dirty),
        .req            (req),
        .mem_complete_r (mem_complete_r),
        .mem_complete_w (mem_complete_w),
        .victim_addr    (victim_addr),
        .capture        (capture),
        .victim_way     (victim_way),
        .fill_go        (fill_go),
        .active_req     (active_req),
        .busy           (busy),
        .mem_re         (mem_re),
        .mem_we         (mem_we),
        .mem_addr       (mem_addr)
    );

    // victim line goes straight out as write data
    victim_select #(
        .L2_WAYS (L2_WAYS)
    ) u_victim (
        .clk         (clk),
        .rst_n       (rst_n),
        .capture     (capture),
        .victim_way  (victim_way),
        .way_tags    (way_tags),
        .way_lines   (way_lines),
        .set         (addr_l2_set(req.addr)),  // set of the incoming miss
        .victim_line (mem_wd),
        .victim_addr (victim_addr)
    );

    fill_router #(
        .L2_WAYS (L2_WAYS)
    ) u_fill (
        .clk        (clk),
        .rst_n      (rst_n),
        .fill_go    (fill_go),
        .active_req (active_req),
        .mem_rd     (mem_rd),
        .l2_fill    (l2_fill),
        .l1_fill    (l1_fill),
        .replay     (replay)
    );

endmodule

`default_nettype wire

// File: hdl/refill_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module refill_fsm import mem_ctrl_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  access_clean,
    input  logic                  access_dirty,
    input  l2_req_t               req,
    input  logic                  mem_complete_r,
    input  logic                  mem_complete_w,
    input  logic [MEM_ADDR_W-1:0] victim_addr,
    output logic                  capture,
    output logic [1:0]            victim_way,
    output logic                  fill_go,
    output l2_req_t               active_req,
    output logic                  busy,
    output logic                  mem_re,
    output logic                  mem_we,
    output logic [MEM_ADDR_W-1:0] mem_addr
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WBACK,  // dirty victim going out
        S_READ,   // waiting for the new line
        S_FILL    // line handed to the fill router
    } state_t;

    state_t state;
    state_t state_nxt;

    logic start_rd;
    logic start_wb;

    ////////////////////
    // acceptance
    ////////////////////
    // L2 holds tags and lines steady only in this cycle,
    // so the victim way goes out with the accept pulse
    assign capture    = !busy && (access_clean || access_dirty);
    assign start_rd   = capture && access_clean;  // clean wins over dirty
    assign start_wb   = capture && !access_clean;
    assign victim_way = req.l2_way;

    assign busy    = (state == S_WBACK) || (state == S_READ);
    assign fill_go = (state == S_READ) && mem_complete_r;  // mem_rd valid now

    ////////////////////
    // next state
    ////////////////////
    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE, S_FILL: begin
                // the fill cycle already has busy low
                if (start_rd) begin
                    state_nxt = S_READ;
                end else if (start_wb) begin
                    state_nxt = S_WBACK;
                end else begin
                    state_nxt = S_IDLE;
                end
            end
            S_WBACK: begin
                if (mem_complete_w) begin
                    state_nxt = S_READ;  // refill right behind the write-back
                end
            end
            S_READ: begin
                if (mem_complete_r) begin
                    state_nxt = S_FILL;
                end
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= S_IDLE;
            mem_re <= 1'b0;
            mem_we <= 1'b0;
        end else begin
            state  <= state_nxt;
            mem_re <= (state_nxt == S_READ);   // level until completion
            mem_we <= (state_nxt == S_WBACK);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_req <= '0;
        end else if (capture) begin
            active_req <= req;
        end
    end

    // victim address while writing back, refill address otherwise
    assign mem_addr = (state == S_WBACK) ? victim_addr : addr_line(active_req.addr);

    ////////////////////
    // checks
    ////////////////////
    a_strobe_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(mem_re && mem_we)
    ) else $error("mem_re and mem_we high together");

    a_fill_in_read: assert property (
        @(posedge clk) disable iff (!rst_n)
        fill_go |-> mem_re
    ) else $error("fill_go outside the read-line state");

endmodule

`default_nettype wire

// File: hdl/victim_select.sv
`timescale 1ns/1ps
`default_nettype none

module victim_select import mem_ctrl_pkg::*; #(
    parameter int L2_WAYS = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        capture,
    input  logic [1:0]                  victim_way,
    input  l2_tag_entry_t [L2_WAYS-1:0] way_tags,
    input  line_t [L2_WAYS-1:0]         way_lines,
    input  logic [L2_SET_W-1:0]         set,
    output line_t                       victim_line,
    output logic [MEM_ADDR_W-1:0]       victim_addr
);

    localparam int SEL_W = (L2_WAYS > 1) ? $clog2(L2_WAYS) : 1;

    logic [SEL_W-1:0] sel;
    l2_tag_entry_t    sel_tag;
    line_t            sel_line;

    assign sel      = SEL_W'(victim_way);
    assign sel_tag  = way_tags[sel];
    assign sel_line = way_lines[sel];

    // held for the whole write-back
    always_ff @(posedge clk) begin
        if (capture) begin
            victim_line <= sel_line;
            victim_addr <= {sel_tag.tag, set};  // old tag, same set
        end
    end

    ////////////////////
    // checks
    ////////////////////
    // the request way must exist in this cache
    a_way_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        capture |-> (int'(victim_way) < L2_WAYS)
    ) else $error("victim way %0d beyond %0d ways", victim_way, L2_WAYS);

endmodule

`default_nettype wire
